//--- compile.f
rst_mgr_pkg.sv
por_if.sv
por_sequencer.sv
fifo_reset_ctrl.sv
adc_init_ctrl.sv
reset_manager.sv
tb_reset_manager.sv

//--- Bender.yml
package:
  name: reset_manager

sources:
  - rst_mgr_pkg.sv
  - por_if.sv
  - por_sequencer.sv
  - fifo_reset_ctrl.sv
  - adc_init_ctrl.sv
  - reset_manager.sv
  - target: test
    files:
      - tb_reset_manager.sv

//--- tb_reset_manager.sv
`timescale 1ns/10ps

module tb_reset_manager;

	localparam int CLK_PERIOD  = 4;
	localparam int MAX_DELAY   = 20; // Responder delays run from 3 to 20 cycles
	localparam int LOCK_GAP    = rst_mgr_pkg::MMCM_RST_CYCLES + rst_mgr_pkg::LOCK_TMO_CYCLES + 2;
	localparam int BRINGUP_MAX = rst_mgr_pkg::STARTUP_DLY_CYCLES + LOCK_GAP
		+ rst_mgr_pkg::FIFO_RST_CYCLES + rst_mgr_pkg::FIFO_RECOVER_CYCLES
		+ rst_mgr_pkg::ADC_RST_CYCLES + 3 * MAX_DELAY + 20;
	localparam int RETRY_MAX   = rst_mgr_pkg::STARTUP_DLY_CYCLES + 3 * LOCK_GAP + 20;
	localparam int TOTAL_CYCLES = 6 * 10 + 20 + BRINGUP_MAX + RETRY_MAX
		+ BRINGUP_MAX + rst_mgr_pkg::ADC_INIT_TMO_CYCLES + 40 + BRINGUP_MAX + 40 + 3 * BRINGUP_MAX;

	logic CLK100KHZ;
	logic EOS;
	logic jtag_sys_rst_i, csp_sys_rst_i, rst_resync_i;
	logic mmcm_lock_i, qpll_lock_i, al_done_i, adc_init_done_i;
	logic mmcm_rst_o, sys_rst_o, adc_init_rst_o, adc_rst_o, adc_init_o, adc_rdy_o;
	logic dsr_rst_o, al_start_o, run_o, daq_fifo_rst_o, slow_fifo_rst_o, slow_fifo_rst_done_o;
	rst_mgr_pkg::por_state_e por_state_o;

	bit         qpll_en, adc_en, al_en;           // Responder enables
	bit         lock_retry_chk, adc_blocked, run_hold;
	int         errors, tests_run, tests_ok;
	int         delay_tab [64];
	int         delay_idx;
	int         mmcm_len, slow_len, daq_len, adc_rst_len, adc_init_len;
	int         mmcm_gap, mmcm_rises, slow_rises, daq_rises;
	logic [6:0] seen_states;

	reset_manager u_reset_manager (.*);

	initial CLK100KHZ = 1'b0;
	always #(CLK_PERIOD / 2) CLK100KHZ = ~CLK100KHZ;

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("** Error at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
		errors++;
	endtask

	task automatic failure(input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else mismatch(name, exp, act);
	endtask

	function automatic int next_delay();
		int d;
		d = delay_tab[delay_idx % 64];
		delay_idx++;
		return d;
	endfunction

	function automatic logic watch_value(input string name);
		case (name)
			"run_o":          return run_o;
			"sys_rst_o":      return sys_rst_o;
			"adc_init_o":     return adc_init_o;
			"daq_fifo_rst_o": return daq_fifo_rst_o;
			default:          return 1'bx;
		endcase
	endfunction

	task automatic wait_level(input string name, input logic level, input int max_cycles);
		int n;
		n = 0;
		while (watch_value(name) !== level && n < max_cycles) begin
			@(negedge CLK100KHZ);
			n++;
		end
		if (watch_value(name) !== level)
			failure($sformatf("%s did not reach %0b within %0d cycles", name, level, max_cycles));
	endtask

	task automatic step_to_drive_point();
		@(posedge CLK100KHZ);
		#1;
	endtask

	task automatic reset_dut();
		step_to_drive_point();
		EOS            = 1'b0;
		jtag_sys_rst_i = 1'b0;
		csp_sys_rst_i  = 1'b0;
		rst_resync_i   = 1'b0;
		lock_retry_chk = 1'b0;
		adc_blocked    = 1'b0;
		run_hold       = 1'b0;
		qpll_en        = 1'b1;
		adc_en         = 1'b1;
		al_en          = 1'b1;
		repeat (8) @(posedge CLK100KHZ);
		#1;
		EOS = 1'b1;
	endtask

	task automatic check_reset_values(input logic clocked);
		check_value("sys_rst_o", 1, sys_rst_o);
		check_value("adc_init_rst_o", 1, adc_init_rst_o);
		check_value("adc_rst_o", 1, adc_rst_o);
		check_value("dsr_rst_o", 1, dsr_rst_o);
		check_value("mmcm_rst_o", 0, mmcm_rst_o);
		check_value("al_start_o", 0, al_start_o);
		check_value("run_o", 0, run_o);
		check_value("adc_init_o", 0, adc_init_o);
		check_value("adc_rdy_o", 0, adc_rdy_o);
		check_value("daq_fifo_rst_o", 0, daq_fifo_rst_o);
		check_value("slow_fifo_rst_done_o", 0, slow_fifo_rst_done_o);
		check_value("slow_fifo_rst_o", clocked, slow_fifo_rst_o); // Rises on the first clock
		check_value("por_state_o", rst_mgr_pkg::ST_STARTUP, por_state_o);
	endtask

	task automatic restart_and_recover(input bit use_csp);
		int rises_before;
		step_to_drive_point();
		rises_before = slow_rises;
		if (use_csp)
			csp_sys_rst_i = 1'b1;
		else
			jtag_sys_rst_i = 1'b1;
		step_to_drive_point();
		jtag_sys_rst_i = 1'b0;
		csp_sys_rst_i  = 1'b0;
		wait_level("sys_rst_o", 1'b1, 6);
		check_value("run_o", 0, run_o);
		wait_level("run_o", 1'b1, BRINGUP_MAX);
		check_value("slow_fifo_rst_o pulse count", rises_before + 1, slow_rises);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			tests_ok++;
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			$display("Test %0d %s: %0d errors", tests_run, name, errors - errors_before);
		end
	endtask

	// Locks come back a while after each clock-manager reset
	initial begin : lock_model
		int   delay;
		logic mmcm_rst_q;
		mmcm_lock_i = 1'b0;
		qpll_lock_i = 1'b0;
		delay       = 0;
		mmcm_rst_q  = 1'b0;
		forever begin
			step_to_drive_point();
			if (!EOS || mmcm_rst_o) begin
				mmcm_lock_i = 1'b0;
				qpll_lock_i = 1'b0;
				delay       = 0;
			end else if (mmcm_rst_q) begin
				delay = next_delay();
			end else if (delay > 0) begin
				delay--;
				if (delay == 0) begin
					mmcm_lock_i = 1'b1;
					qpll_lock_i = qpll_en;
				end
			end
			mmcm_rst_q = mmcm_rst_o;
		end
	end

	initial begin : adc_model
		int   delay;
		logic init_q;
		adc_init_done_i = 1'b0;
		delay           = 0;
		init_q          = 1'b0;
		forever begin
			step_to_drive_point();
			if (!EOS || adc_rst_o) begin
				adc_init_done_i = 1'b0; // ADC loses its setup in reset
				delay           = 0;
			end else if (adc_init_o && !init_q && adc_en) begin
				delay = next_delay();
			end else if (delay > 0) begin
				delay--;
				if (delay == 0)
					adc_init_done_i = 1'b1;
			end
			init_q = adc_init_o;
		end
	end

	initial begin : al_model
		int   delay;
		logic start_q;
		al_done_i = 1'b0;
		delay     = 0;
		start_q   = 1'b0;
		forever begin
			step_to_drive_point();
			if (!EOS || !al_start_o) begin
				al_done_i = 1'b0;
				delay     = 0;
			end else if (!start_q && al_en) begin
				delay = next_delay();
			end else if (delay > 0) begin
				delay--;
				if (delay == 0)
					al_done_i = 1'b1;
			end
			start_q = al_start_o;
		end
	end

	// Pulse lengths, gaps and edge counts seen at each rising edge
	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			mmcm_len     <= 0;
			slow_len     <= 0;
			daq_len      <= 0;
			adc_rst_len  <= 0;
			adc_init_len <= 0;
			mmcm_gap     <= 0;
			mmcm_rises   <= 0;
			slow_rises   <= 0;
			daq_rises    <= 0;
			seen_states  <= '0;
		end else begin
			mmcm_len     <= mmcm_rst_o ? mmcm_len + 1 : 0;
			slow_len     <= slow_fifo_rst_o ? slow_len + 1 : 0;
			daq_len      <= daq_fifo_rst_o ? daq_len + 1 : 0;
			adc_rst_len  <= (adc_rst_o && !adc_init_rst_o) ? adc_rst_len + 1 : 0;
			adc_init_len <= adc_init_o ? adc_init_len + 1 : 0;
			mmcm_gap     <= (mmcm_rst_o && mmcm_len == 0) ? 1 : mmcm_gap + 1;
			if (mmcm_rst_o && mmcm_len == 0)
				mmcm_rises <= mmcm_rises + 1;
			if (slow_fifo_rst_o && slow_len == 0)
				slow_rises <= slow_rises + 1;
			if (daq_fifo_rst_o && daq_len == 0)
				daq_rises <= daq_rises + 1;
			seen_states[por_state_o] <= 1'b1;
		end
	end

	a_dsr: assert property (@(posedge CLK100KHZ) dsr_rst_o == (!adc_rdy_o || sys_rst_o))
		else mismatch("dsr_rst_o", $sampled(!adc_rdy_o || sys_rst_o), $sampled(dsr_rst_o));
	a_por_pair: assert property (@(posedge CLK100KHZ) adc_init_rst_o == sys_rst_o)
		else mismatch("adc_init_rst_o", $sampled(sys_rst_o), $sampled(adc_init_rst_o));
	a_por_state: assert property (@(posedge CLK100KHZ)
		sys_rst_o == (por_state_o < rst_mgr_pkg::ST_ADC_INIT))
		else mismatch("sys_rst_o", $sampled(por_state_o < rst_mgr_pkg::ST_ADC_INIT),
			$sampled(sys_rst_o));
	a_mmcm_len: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		$fell(mmcm_rst_o) |-> mmcm_len == rst_mgr_pkg::MMCM_RST_CYCLES)
		else mismatch("mmcm_rst_o pulse length", rst_mgr_pkg::MMCM_RST_CYCLES, $sampled(mmcm_len));
	a_slow_len: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		$fell(slow_fifo_rst_o) |-> slow_len == rst_mgr_pkg::FIFO_RST_CYCLES)
		else mismatch("slow_fifo_rst_o pulse length", rst_mgr_pkg::FIFO_RST_CYCLES,
			$sampled(slow_len));
	a_daq_len: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		$fell(daq_fifo_rst_o) |-> daq_len == rst_mgr_pkg::FIFO_RST_CYCLES)
		else mismatch("daq_fifo_rst_o pulse length", rst_mgr_pkg::FIFO_RST_CYCLES, $sampled(daq_len));
	a_adc_rst_len: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		$fell(adc_rst_o) |-> adc_rst_len == rst_mgr_pkg::ADC_RST_CYCLES)
		else mismatch("adc_rst_o length", rst_mgr_pkg::ADC_RST_CYCLES, $sampled(adc_rst_len));
	a_adc_tmo: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		$fell(adc_init_o) && !adc_rdy_o && !adc_init_rst_o
		|-> adc_init_len == rst_mgr_pkg::ADC_INIT_TMO_CYCLES)
		else mismatch("adc_init_o length", rst_mgr_pkg::ADC_INIT_TMO_CYCLES, $sampled(adc_init_len));
	a_frst_first: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		$fell(sys_rst_o) |-> slow_fifo_rst_done_o)
		else failure("sys_rst_o fell before slow_fifo_rst_done_o rose");
	a_rdy_first: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		$rose(al_start_o) |-> adc_rdy_o)
		else failure("al_start_o rose while adc_rdy_o was low");
	a_al_first: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		$rose(run_o) |-> $past(al_start_o))
		else failure("run_o rose without al_start_o before it");
	a_state_order: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		por_state_o != $past(por_state_o) && por_state_o != rst_mgr_pkg::ST_MMCM_RST
		|-> int'(por_state_o) == int'($past(por_state_o)) + 1)
		else mismatch("por_state_o", $sampled(int'($past(por_state_o)) + 1), $sampled(por_state_o));
	a_lock_gap: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		lock_retry_chk && $rose(mmcm_rst_o) && mmcm_rises != 0 |-> mmcm_gap == LOCK_GAP)
		else mismatch("mmcm_rst_o retry spacing", LOCK_GAP, $sampled(mmcm_gap));
	a_retry_quiet: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		lock_retry_chk |-> !run_o && !al_start_o)
		else failure("run_o or al_start_o rose without both locks");
	a_adc_blocked: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		adc_blocked |-> !adc_rdy_o && dsr_rst_o && !run_o)
		else failure("ADC reported ready with no init-done response");
	a_run_hold: assert property (@(posedge CLK100KHZ) disable iff (!EOS)
		run_hold |-> run_o && !sys_rst_o)
		else failure("resync disturbed run_o or sys_rst_o");

	initial begin
		int errors_before;
		int n;
		void'($urandom(84));
		foreach (delay_tab[i])
			delay_tab[i] = 3 + ($urandom % 18);
		EOS            = 1'b0;
		jtag_sys_rst_i = 1'b0;
		csp_sys_rst_i  = 1'b0;
		rst_resync_i   = 1'b0;
		qpll_en        = 1'b1;
		adc_en         = 1'b1;
		al_en          = 1'b1;

		errors_before = errors;
		repeat (7) @(negedge CLK100KHZ);
		check_reset_values(1'b0);
		step_to_drive_point();
		EOS = 1'b1;
		@(posedge CLK100KHZ);
		@(negedge CLK100KHZ);
		check_reset_values(1'b1);
		finish_test("reset values", errors_before);

		errors_before = errors;
		reset_dut();
		wait_level("run_o", 1'b1, BRINGUP_MAX);
		step_to_drive_point(); // ST_RUN is logged on the next edge
		check_value("states visited", 7'h7f, seen_states);
		finish_test("full bring-up", errors_before);

		errors_before = errors;
		reset_dut();
		qpll_en        = 1'b0;
		lock_retry_chk = 1'b1;
		n = 0;
		while (mmcm_rises < 3 && n < RETRY_MAX) begin
			@(negedge CLK100KHZ);
			n++;
		end
		if (mmcm_rises < 3)
			failure("mmcm_rst_o did not retry twice with qpll_lock_i low");
		step_to_drive_point();
		lock_retry_chk = 1'b0;
		finish_test("lock timeout", errors_before);

		errors_before = errors;
		reset_dut();
		adc_en      = 1'b0;
		adc_blocked = 1'b1;
		wait_level("adc_init_o", 1'b1, BRINGUP_MAX);
		wait_level("adc_init_o", 1'b0, rst_mgr_pkg::ADC_INIT_TMO_CYCLES + 10);
		check_value("adc_rst_o", 1, adc_rst_o);
		wait_level("adc_init_o", 1'b1, rst_mgr_pkg::ADC_RST_CYCLES + 10); // Second attempt
		step_to_drive_point();
		adc_blocked = 1'b0;
		finish_test("ADC timeout", errors_before);

		errors_before = errors;
		reset_dut();
		wait_level("run_o", 1'b1, BRINGUP_MAX);
		step_to_drive_point();
		run_hold     = 1'b1;
		n            = daq_rises;
		rst_resync_i = 1'b1;
		step_to_drive_point();
		rst_resync_i = 1'b0;
		wait_level("daq_fifo_rst_o", 1'b1, 5);
		wait_level("daq_fifo_rst_o", 1'b0, rst_mgr_pkg::FIFO_RST_CYCLES + 5);
		repeat (10) @(negedge CLK100KHZ);
		check_value("daq_fifo_rst_o pulse count", n + 1, daq_rises);
		step_to_drive_point();
		run_hold = 1'b0;
		finish_test("resync in run", errors_before);

		errors_before = errors;
		reset_dut();
		wait_level("run_o", 1'b1, BRINGUP_MAX);
		restart_and_recover(1'b0);
		restart_and_recover(1'b1);
		finish_test("restart", errors_before);

		$display("Summary: %0d tests, %0d ok, %0d with errors, %0d errors in total",
			tests_run, tests_ok, tests_run - tests_ok, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		#(TOTAL_CYCLES * CLK_PERIOD * 3 / 2);
		$display("Watchdog expired at %0d ns before the run finished", $time);
		$display("test failed");
		$finish;
	end

endmodule

//--- reset_manager.sv
`timescale 1ns/10ps

module reset_manager (
	input  logic                    CLK100KHZ,
	input  logic                    EOS,
	input  logic                    jtag_sys_rst_i,
	input  logic                    csp_sys_rst_i,
	input  logic                    rst_resync_i,
	input  logic                    mmcm_lock_i,
	input  logic                    qpll_lock_i,
	input  logic                    al_done_i,
	input  logic                    adc_init_done_i,
	output logic                    mmcm_rst_o,
	output logic                    sys_rst_o,
	output logic                    adc_init_rst_o,
	output logic                    adc_rst_o,
	output logic                    adc_init_o,
	output logic                    adc_rdy_o,
	output logic                    dsr_rst_o,
	output logic                    al_start_o,
	output logic                    run_o,
	output logic                    daq_fifo_rst_o,
	output logic                    slow_fifo_rst_o,
	output logic                    slow_fifo_rst_done_o,
	output rst_mgr_pkg::por_state_e por_state_o
);

	por_if por_bus ();

	por_sequencer u_por_sequencer (
		.CLK100KHZ      (CLK100KHZ),
		.EOS            (EOS),
		.jtag_sys_rst_i (jtag_sys_rst_i),
		.csp_sys_rst_i  (csp_sys_rst_i),
		.mmcm_lock_i    (mmcm_lock_i),
		.qpll_lock_i    (qpll_lock_i),
		.al_done_i      (al_done_i),
		.por_bus        (por_bus.seq_mp),
		.mmcm_rst_o     (mmcm_rst_o),
		.al_start_o     (al_start_o),
		.run_o          (run_o),
		.por_state_o    (por_state_o)
	);

	// Auto-load FIFO reset, fired by each rise of the system reset
	fifo_reset_ctrl u_slow_fifo_rst (
		.CLK100KHZ  (CLK100KHZ),
		.EOS        (EOS),
		.trig_i     (por_bus.por),
		.fifo_rst_o (slow_fifo_rst_o),
		.done_o     (por_bus.slow_frst_done)
	);

	// DAQ FIFO reset on resync
	fifo_reset_ctrl u_daq_fifo_rst (
		.CLK100KHZ  (CLK100KHZ),
		.EOS        (EOS),
		.trig_i     (rst_resync_i),
		.fifo_rst_o (daq_fifo_rst_o),
		.done_o     ()
	);

	adc_init_ctrl u_adc_init_ctrl (
		.CLK100KHZ       (CLK100KHZ),
		.EOS             (EOS),
		.adc_init_done_i (adc_init_done_i),
		.por_bus         (por_bus.adc_mp),
		.adc_rst_o       (adc_rst_o),
		.adc_init_o      (adc_init_o),
		.dsr_rst_o       (dsr_rst_o)
	);

	assign sys_rst_o            = por_bus.por;
	assign adc_init_rst_o       = por_bus.adc_init_rst;
	assign adc_rdy_o            = por_bus.adc_rdy;
	assign slow_fifo_rst_done_o = por_bus.slow_frst_done;

endmodule

//--- adc_init_ctrl.sv
`timescale 1ns/10ps

module adc_init_ctrl (
	input  logic  CLK100KHZ,
	input  logic  EOS,
	input  logic  adc_init_done_i,
	por_if.adc_mp por_bus,
	output logic  adc_rst_o,
	output logic  adc_init_o,
	output logic  dsr_rst_o
);

	logic                    done_q1;
	logic                    done_s;
	logic                    adc_rdy;
	rst_mgr_pkg::adc_state_e state;
	rst_mgr_pkg::tmr_t       tmr;

	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			done_q1 <= 1'b0;
			done_s  <= 1'b0;
		end else begin
			done_q1 <= adc_init_done_i;
			done_s  <= done_q1;
		end
	end

	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			state <= rst_mgr_pkg::ADC_HOLD;
			tmr   <= '0;
		end else if (por_bus.adc_init_rst) begin
			state <= rst_mgr_pkg::ADC_HOLD;
			tmr   <= '0;
		end else begin
			case (state)
				rst_mgr_pkg::ADC_HOLD: begin
					// Release cycle is the first cycle of the ADC reset
					state <= rst_mgr_pkg::ADC_RST;
					tmr   <= rst_mgr_pkg::tmr_t'(1);
				end
				rst_mgr_pkg::ADC_RST: begin
					if (tmr == rst_mgr_pkg::ADC_RST_CYCLES - 1'b1) begin
						state <= rst_mgr_pkg::ADC_INIT;
						tmr   <= '0;
					end else begin
						tmr <= tmr + 1'b1;
					end
				end
				rst_mgr_pkg::ADC_INIT: begin
					if (done_s) begin
						state <= rst_mgr_pkg::ADC_READY;
						tmr   <= '0;
					end else if (tmr == rst_mgr_pkg::ADC_INIT_TMO_CYCLES - 1'b1) begin
						state <= rst_mgr_pkg::ADC_RST; // No response, retry
						tmr   <= '0;
					end else begin
						tmr <= tmr + 1'b1;
					end
				end
				rst_mgr_pkg::ADC_READY: begin
					state <= rst_mgr_pkg::ADC_READY; // Left only on ADC-init reset
				end
				default: begin
					state <= rst_mgr_pkg::ADC_HOLD;
					tmr   <= '0;
				end
			endcase
		end
	end

	assign adc_rdy    = (state == rst_mgr_pkg::ADC_READY);
	assign adc_rst_o  = (state == rst_mgr_pkg::ADC_HOLD) || (state == rst_mgr_pkg::ADC_RST);
	assign adc_init_o = (state == rst_mgr_pkg::ADC_INIT);
	assign dsr_rst_o  = ~adc_rdy | por_bus.por; // Deserialisers wait for the ADC

	assign por_bus.adc_rdy = adc_rdy;

endmodule

//--- fifo_reset_ctrl.sv
`timescale 1ns/10ps

module fifo_reset_ctrl (
	input  logic CLK100KHZ,
	input  logic EOS,
	input  logic trig_i,
	output logic fifo_rst_o,
	output logic done_o
);

	logic                   trig_d;
	logic                   recover;
	rst_mgr_pkg::fifo_cnt_t cnt;

	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			trig_d     <= 1'b0; // Trigger seen as low before reset
			recover    <= 1'b0;
			cnt        <= '0;
			fifo_rst_o <= 1'b0;
			done_o     <= 1'b0;
		end else begin
			trig_d <= trig_i;
			if (trig_i && !trig_d) begin
				// New request restarts any sequence in progress
				fifo_rst_o <= 1'b1;
				recover    <= 1'b0;
				cnt        <= '0;
				done_o     <= 1'b0;
			end else if (fifo_rst_o) begin
				if (cnt == rst_mgr_pkg::FIFO_RST_CYCLES - 1'b1) begin
					fifo_rst_o <= 1'b0;
					recover    <= 1'b1;
					cnt        <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else if (recover) begin
				if (cnt == rst_mgr_pkg::FIFO_RECOVER_CYCLES - 1'b1) begin
					recover <= 1'b0;
					cnt     <= '0;
					done_o  <= 1'b1; // Held until the next edge
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- por_sequencer.sv
`timescale 1ns/10ps

module por_sequencer (
	input  logic                    CLK100KHZ,
	input  logic                    EOS,
	input  logic                    jtag_sys_rst_i,
	input  logic                    csp_sys_rst_i,
	input  logic                    mmcm_lock_i,
	input  logic                    qpll_lock_i,
	input  logic                    al_done_i,
	por_if.seq_mp                   por_bus,
	output logic                    mmcm_rst_o,
	output logic                    al_start_o,
	output logic                    run_o,
	output rst_mgr_pkg::por_state_e por_state_o
);

	logic [4:0]              sync_q1;
	logic [4:0]              sync_q2;
	logic                    mmcm_lock_s;
	logic                    qpll_lock_s;
	logic                    restart_s;
	logic                    al_done_s;
	logic                    locked;
	logic                    in_reset;
	rst_mgr_pkg::por_state_e state;
	rst_mgr_pkg::tmr_t       tmr;

	// Two-flop synchronisers for all asynchronous inputs
	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= {al_done_i, csp_sys_rst_i, jtag_sys_rst_i, qpll_lock_i, mmcm_lock_i};
			sync_q2 <= sync_q1;
		end
	end

	assign mmcm_lock_s = sync_q2[0];
	assign qpll_lock_s = sync_q2[1];
	assign restart_s   = sync_q2[2] | sync_q2[3]; // JTAG or CSP system reset
	assign al_done_s   = sync_q2[4];
	assign locked      = mmcm_lock_s & qpll_lock_s;

	always_ff @(posedge CLK100KHZ or negedge EOS) begin
		if (!EOS) begin
			state <= rst_mgr_pkg::ST_STARTUP;
			tmr   <= '0;
		end else if (restart_s && state != rst_mgr_pkg::ST_STARTUP) begin
			state <= rst_mgr_pkg::ST_MMCM_RST;
			tmr   <= '0;
		end else begin
			case (state)
				rst_mgr_pkg::ST_STARTUP: begin
					if (tmr == rst_mgr_pkg::STARTUP_DLY_CYCLES - 1'b1) begin
						state <= rst_mgr_pkg::ST_MMCM_RST;
						tmr   <= '0;
					end else begin
						tmr <= tmr + 1'b1;
					end
				end
				rst_mgr_pkg::ST_MMCM_RST: begin
					if (tmr == rst_mgr_pkg::MMCM_RST_CYCLES - 1'b1) begin
						state <= rst_mgr_pkg::ST_WAIT_LOCK;
						tmr   <= '0;
					end else begin
						tmr <= tmr + 1'b1;
					end
				end
				rst_mgr_pkg::ST_WAIT_LOCK: begin
					if (locked) begin
						state <= rst_mgr_pkg::ST_FIFO_RST;
						tmr   <= '0;
					end else if (tmr == rst_mgr_pkg::LOCK_TMO_CYCLES + 1'b1) begin
						// Timeout window starts once the synchronisers have caught up
						state <= rst_mgr_pkg::ST_MMCM_RST;
						tmr   <= '0;
					end else begin
						tmr <= tmr + 1'b1;
					end
				end
				rst_mgr_pkg::ST_FIFO_RST: begin
					if (por_bus.slow_frst_done) begin
						state <= rst_mgr_pkg::ST_ADC_INIT;
					end
				end
				rst_mgr_pkg::ST_ADC_INIT: begin
					if (!locked) begin
						state <= rst_mgr_pkg::ST_MMCM_RST; // Lock lost, start over
					end else if (por_bus.adc_rdy) begin
						state <= rst_mgr_pkg::ST_AL_START;
					end
				end
				rst_mgr_pkg::ST_AL_START: begin
					if (!locked) begin
						state <= rst_mgr_pkg::ST_MMCM_RST;
					end else if (al_done_s) begin
						state <= rst_mgr_pkg::ST_RUN;
					end
				end
				rst_mgr_pkg::ST_RUN: begin
					if (!locked) begin
						state <= rst_mgr_pkg::ST_MMCM_RST;
					end
				end
				default: begin
					state <= rst_mgr_pkg::ST_STARTUP;
					tmr   <= '0;
				end
			endcase
		end
	end

	// Everything before ADC init keeps the board in reset
	assign in_reset = (state < rst_mgr_pkg::ST_ADC_INIT);

	assign por_bus.por          = in_reset;
	assign por_bus.adc_init_rst = in_reset;
	assign mmcm_rst_o           = (state == rst_mgr_pkg::ST_MMCM_RST);
	assign al_start_o           = (state == rst_mgr_pkg::ST_AL_START);
	assign run_o                = (state == rst_mgr_pkg::ST_RUN);
	assign por_state_o          = state;

endmodule

//--- por_if.sv
`timescale 1ns/10ps

interface por_if ();

	logic por;            // System reset
	logic adc_init_rst;   // Holds the ADC controller
	logic adc_rdy;        // ADC initialised
	logic slow_frst_done; // Slow FIFO reset finished

	modport seq_mp (
		output por,
		output adc_init_rst,
		input  adc_rdy,
		input  slow_frst_done
	);

	modport adc_mp (
		input  por,
		input  adc_init_rst,
		output adc_rdy
	);

	modport fifo_mp (
		input  por,
		output slow_frst_done
	);

endinterface

//--- rst_mgr_pkg.sv
package rst_mgr_pkg;

	// Counter widths
	localparam int TMR_W      = 12; // Sequencer and ADC timers
	localparam int FIFO_CNT_W = 4;  // FIFO reset pulse and recovery counter

	typedef logic [TMR_W-1:0]      tmr_t;
	typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

	// Sequencer timing, in CLK100KHZ cycles
	localparam tmr_t STARTUP_DLY_CYCLES = tmr_t'(32);
	localparam tmr_t MMCM_RST_CYCLES    = tmr_t'(4);
	localparam tmr_t LOCK_TMO_CYCLES    = tmr_t'(120); // Per clock-manager reset attempt

	// FIFO reset timing
	localparam fifo_cnt_t FIFO_RST_CYCLES     = fifo_cnt_t'(8);
	localparam fifo_cnt_t FIFO_RECOVER_CYCLES = fifo_cnt_t'(4);

	// ADC bring-up timing
	localparam tmr_t ADC_RST_CYCLES      = tmr_t'(4);
	localparam tmr_t ADC_INIT_TMO_CYCLES = tmr_t'(1000); // 10 ms at 100 kHz

	// Power-on sequencer states, exported on por_state_o
	typedef enum logic [3:0] {
		ST_STARTUP   = 4'd0,
		ST_MMCM_RST  = 4'd1,
		ST_WAIT_LOCK = 4'd2,
		ST_FIFO_RST  = 4'd3,
		ST_ADC_INIT  = 4'd4,
		ST_AL_START  = 4'd5,
		ST_RUN       = 4'd6
	} por_state_e;

	// ADC initialisation states
	typedef enum logic [1:0] {
		ADC_HOLD  = 2'd0, // Held by the ADC-init reset
		ADC_RST   = 2'd1,
		ADC_INIT  = 2'd2,
		ADC_READY = 2'd3
	} adc_state_e;

endpackage
